// File: rtl/cart_pkg.sv
`default_nettype none

package cart_pkg;

	// ==================================================
	// Widths and vectors
	// ==================================================
	localparam int IO_ADDR_W = 25;
	localparam int BK_ADDR_W = 16;

	typedef logic [IO_ADDR_W-1:0] io_addr_t;
	typedef logic [15:0]          word_t;
	typedef logic [23:0]          rom_addr_t;
	typedef logic [23:0]          mask_t;
	typedef logic [31:0]          lba_t;
	typedef logic [7:0]           byte_t;
	typedef logic [BK_ADDR_W-1:0] bk_addr_t;

	// ==================================================
	// State and code enums
	// ==================================================
	typedef enum logic [1:0] {AUTO, LOROM, HIROM, EXHIROM} rom_layout_e;

	// Upper nibble of the ROM type code
	typedef enum logic [3:0] {
		NONE    = 4'h0,
		CX4     = 4'h4,
		SDD1    = 4'h5,
		SA1     = 4'h6,
		GSU     = 4'h7,
		ST0XX   = 4'h8,
		DSP2    = 4'h9,
		DSP3    = 4'hA,
		DSP4    = 4'hB,
		OBC1    = 4'hC,
		SPC7110 = 4'hD
	} chip_e;

	typedef enum logic {IDLE, XFER} bk_state_e;

	// ==================================================
	// Bundles
	// ==================================================
	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic        wr;
		io_addr_t    addr;
		word_t       dout;
		logic [23:0] filesize;
	} ioctl_t;

	typedef struct packed {
		logic [7:0] rom_type;
		mask_t      rom_mask;
		mask_t      ram_mask;
	} cart_info_t;

	typedef struct packed {
		byte_t      mapper;
		byte_t      type_code;
		byte_t      company;
		logic [3:0] rom_size;
		logic [3:0] ram_size;
	} hdr_fields_t;

	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		bk_addr_t adr;
		word_t    dat;
		logic [1:0] sel;
	} wb_m2s_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_s2m_t;

	// Header byte offsets within the bank
	localparam logic [14:0] HDR_MAPPER_OFS  = 15'h7FD4;
	localparam logic [14:0] HDR_TYPE_OFS    = 15'h7FD6;
	localparam logic [14:0] HDR_RAM_OFS     = 15'h7FD8;
	localparam logic [14:0] HDR_COMPANY_OFS = 15'h7FDA;

	// SPC file layout
	localparam io_addr_t ARAM_OFS   = 25'd256;
	localparam io_addr_t ARAM_LIMIT = 25'h10100;

	localparam int GSU_RAM_KB_LOG = 6;

endpackage

`default_nettype wire

// File: rtl/download_router.sv
`default_nettype none

module download_router (
	input  wire                 clk_sys,
	input  wire                 RESET_N,
	input  wire cart_pkg::ioctl_t ioctl,
	output logic                cart_active,
	output cart_pkg::io_addr_t  io_addr_adj,
	output logic                rom_wr,
	output cart_pkg::rom_addr_t rom_addr,
	output cart_pkg::word_t     rom_data,
	output logic                aram_wr,
	output logic [15:0]         aram_addr,
	output cart_pkg::word_t     aram_data,
	output logic                spc_mode,
	output logic                dl_start
);

	logic               spc_active;
	logic               dl_prev;
	cart_pkg::io_addr_t aram_rel;

	// Index 0/1 is a cartridge image and index 2 an SPC file
	assign cart_active = ioctl.download && (ioctl.index[5:1] == 5'd0);
	assign spc_active  = ioctl.download && (ioctl.index[5:0] == 6'd2);

	// Strips a 512 byte copier header
	assign io_addr_adj = ioctl.addr - cart_pkg::io_addr_t'(ioctl.filesize[9:0]);
	assign aram_rel    = ioctl.addr - cart_pkg::ARAM_OFS;

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			rom_wr   <= 1'b0;
			aram_wr  <= 1'b0;
			spc_mode <= 1'b0;
			dl_prev  <= 1'b0;
			dl_start <= 1'b0;
		end else begin
			rom_wr   <= cart_active && ioctl.wr;
			aram_wr  <= spc_active && ioctl.wr && (ioctl.addr < cart_pkg::ARAM_LIMIT);
			if (ioctl.wr)
				spc_mode <= spc_active;
			dl_prev  <= ioctl.download;
			dl_start <= ioctl.download && !dl_prev;
		end
	end

	// Write payload
	always_ff @(posedge clk_sys) begin
		if (ioctl.wr) begin
			rom_addr  <= io_addr_adj[23:0];
			rom_data  <= ioctl.dout;
			aram_addr <= aram_rel[15:0];
			aram_data <= ioctl.dout;
		end
	end

endmodule

`default_nettype wire

// File: rtl/header_capture.sv
`default_nettype none

module header_capture (
	input  wire                        clk_sys,
	input  wire                        RESET_N,
	input  wire cart_pkg::ioctl_t      ioctl,
	input  wire                        cart_active,
	input  wire cart_pkg::io_addr_t    io_addr_adj,
	input  wire cart_pkg::rom_layout_e rom_layout,
	output logic [1:0]                 layout,
	output cart_pkg::hdr_fields_t      hdr
);

	logic [1:0] eff_layout;
	logic [8:0] prefix;
	logic       hit_mapper;
	logic       hit_type;
	logic       hit_ram;
	logic       hit_company;
	logic       cart_wr;

	// Menu selection wins over the index bits
	assign eff_layout = (rom_layout == cart_pkg::AUTO) ? ioctl.index[7:6] :
	                    2'(rom_layout - 1);

	// ExHiROM header sits at 0x40FFxx, HiROM at 0xFFxx, LoROM at 0x7Fxx
	assign prefix = (eff_layout == 2'd2) ? {8'h40, 1'b1} :
	                (eff_layout == 2'd1) ? {8'h00, 1'b1} : 9'd0;

	assign hit_mapper  = io_addr_adj == cart_pkg::io_addr_t'({prefix, cart_pkg::HDR_MAPPER_OFS});
	assign hit_type    = io_addr_adj == cart_pkg::io_addr_t'({prefix, cart_pkg::HDR_TYPE_OFS});
	assign hit_ram     = io_addr_adj == cart_pkg::io_addr_t'({prefix, cart_pkg::HDR_RAM_OFS});
	assign hit_company = io_addr_adj == cart_pkg::io_addr_t'({prefix, cart_pkg::HDR_COMPANY_OFS});
	assign cart_wr     = cart_active && ioctl.wr;

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			layout <= 2'd0;
			hdr    <= '0;
		end else if (cart_wr) begin
			// First word of a new image
			if (ioctl.addr == '0) begin
				layout       <= eff_layout;
				hdr.ram_size <= 4'd0;
			end
			if (hit_mapper)
				hdr.mapper <= ioctl.dout[15:8];
			if (hit_type)
				{hdr.rom_size, hdr.type_code} <= ioctl.dout[11:0];
			if (hit_ram)
				hdr.ram_size <= ioctl.dout[3:0];
			if (hit_company)
				hdr.company <= ioctl.dout[7:0];
		end
	end

endmodule

`default_nettype wire

// File: rtl/chip_detect.sv
`default_nettype none

module chip_detect (
	input  wire                        clk_sys,
	input  wire                        RESET_N,
	input  wire                        cart_active,
	input  wire [1:0]                  layout,
	input  wire cart_pkg::hdr_fields_t hdr,
	output cart_pkg::cart_info_t       info
);

	cart_pkg::chip_e  chip;
	logic             flag3;
	logic             st_small;
	logic             gsu_ram;
	logic [3:0]       nibble;
	logic [3:0]       rom_shift;
	cart_pkg::mask_t  rom_mask_n;
	cart_pkg::mask_t  ram_mask_n;
	logic [7:0]       m;
	logic [7:0]       t;

	assign m = hdr.mapper;
	assign t = hdr.type_code;

	// ==================================================
	// Rule table, first match wins
	// ==================================================
	always_comb begin
		chip     = cart_pkg::NONE;
		flag3    = 1'b0;
		st_small = 1'b0;
		gsu_ram  = 1'b0;
		if (m == 8'h30 && t == 8'h05 && hdr.company == 8'hB2)
			chip = cart_pkg::DSP3;
		else if (((m == 8'h20 || m == 8'h21) && t == 8'h03) || (m == 8'h30 && t == 8'h05) ||
		         (m == 8'h31 && (t == 8'h03 || t == 8'h05)))
			chip = cart_pkg::ST0XX;  // DSP1 is bit 7 alone
		else if (m == 8'h20 && t == 8'h05)
			chip = cart_pkg::DSP2;
		else if (m == 8'h30 && t == 8'h03)
			chip = cart_pkg::DSP4;
		else if (m == 8'h30 && t == 8'h25)
			chip = cart_pkg::OBC1;
		else if (m == 8'h32 && (t == 8'h43 || t == 8'h45))
			chip = cart_pkg::SDD1;
		else if (m == 8'h30 && t == 8'hF6) begin
			chip     = cart_pkg::ST0XX;
			flag3    = 1'b1;
			st_small = hdr.rom_size < 4'd10;
		end else if (m == 8'h20 && (t == 8'h13 || t == 8'h14 || t == 8'h15 || t == 8'h1A)) begin
			chip    = cart_pkg::GSU;
			gsu_ram = 1'b1;
		end else if (m == 8'h23 && (t == 8'h32 || t == 8'h34 || t == 8'h35))
			chip = cart_pkg::SA1;
		else if (m == 8'h3A && (t == 8'hF5 || t == 8'hF9)) begin
			chip  = cart_pkg::SPC7110;
			flag3 = t[3];  // RTC variant
		end else if (m == 8'h20 && t == 8'hF3)
			chip = cart_pkg::CX4;
	end

	assign nibble    = chip | {2'b00, st_small, 1'b0};
	assign rom_shift = (hdr.rom_size < 4'd12) ? 4'd12 : hdr.rom_size;
	assign rom_mask_n = (cart_pkg::mask_t'(1024) << rom_shift) - cart_pkg::mask_t'(1);

	// GSU carts always get 64 KiB of RAM
	assign ram_mask_n = gsu_ram ?
		(cart_pkg::mask_t'(1024) << cart_pkg::GSU_RAM_KB_LOG) - cart_pkg::mask_t'(1) :
		(hdr.ram_size != 4'd0) ?
		(cart_pkg::mask_t'(1024) << hdr.ram_size) - cart_pkg::mask_t'(1) : '0;

	// Held while an image is still arriving
	always_ff @(posedge clk_sys) begin
		if (!RESET_N)
			info <= '0;
		else if (!cart_active) begin
			info.rom_type <= {nibble, flag3, 1'b0, layout};
			info.rom_mask <= rom_mask_n;
			info.ram_mask <= ram_mask_n;
		end
	end

endmodule

`default_nettype wire

// File: rtl/backup_engine.sv
`default_nettype none

module backup_engine (
	input  wire                    clk_sys,
	input  wire                    RESET_N,
	input  wire                    img_mounted,
	input  wire [31:0]             img_size,
	input  wire                    bk_save,
	input  wire                    dl_start,
	input  wire                    sd_ack,
	input  wire [8:0]              sd_buff_addr,
	input  wire cart_pkg::byte_t   sd_buff_dout,
	input  wire                    sd_buff_wr,
	input  wire                    sd_buff_rd,
	input  wire cart_pkg::wb_s2m_t wb_in,
	output cart_pkg::lba_t         sd_lba,
	output logic                   sd_rd,
	output logic                   sd_wr,
	output cart_pkg::byte_t        sd_buff_din,
	output logic                   bk_ena,
	output logic                   bk_busy,
	output cart_pkg::wb_m2s_t      wb_out
);

	cart_pkg::bk_state_e state;
	logic                load;
	logic [11:0]         sav_size;
	logic                mounted_d;
	logic                save_d;
	logic                ack_d;
	logic                start_load;
	logic                start_save;
	logic                wr_req;
	logic                rd_req;
	logic                cyc_q;
	logic                we_q;
	cart_pkg::bk_addr_t  adr_q;
	cart_pkg::bk_addr_t  wb_ptr;
	cart_pkg::word_t     dat_q;
	cart_pkg::word_t     hold;
	cart_pkg::byte_t     lo_byte;

	assign start_load = (state == cart_pkg::IDLE) && img_mounted && !mounted_d && (|img_size);
	assign start_save = (state == cart_pkg::IDLE) && !start_load && bk_save && !save_d && bk_ena;
	assign wr_req = (state == cart_pkg::XFER) && load && sd_buff_wr && sd_buff_addr[0];
	assign rd_req = start_save ||
	                ((state == cart_pkg::XFER) && !load && sd_buff_rd && sd_buff_addr[0]);

	assign bk_busy     = (state == cart_pkg::XFER);
	assign sd_buff_din = sd_buff_addr[0] ? hold[15:8] : hold[7:0];
	assign wb_out = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, dat: dat_q, sel: 2'b11};

	// ==================================================
	// Sector sequencing
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			state     <= cart_pkg::IDLE;
			load      <= 1'b0;
			bk_ena    <= 1'b0;
			sd_rd     <= 1'b0;
			sd_wr     <= 1'b0;
			sd_lba    <= '0;
			sav_size  <= '0;
			mounted_d <= 1'b0;
			save_d    <= 1'b0;
			ack_d     <= 1'b0;
		end else begin
			mounted_d <= img_mounted;
			save_d    <= bk_save;
			ack_d     <= sd_ack;
			if (sd_ack && !ack_d) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			if (start_load || start_save) begin
				state  <= cart_pkg::XFER;
				load   <= start_load;
				sd_rd  <= start_load;
				sd_wr  <= start_save;
				sd_lba <= '0;
			end else if (state == cart_pkg::XFER && ack_d && !sd_ack) begin
				if (sd_lba[11:0] == sav_size)
					state <= cart_pkg::IDLE;
				else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= load;
					sd_wr  <= !load;
				end
			end
			if (img_mounted && !mounted_d) begin
				bk_ena   <= |img_size;
				sav_size <= img_size[20:9];
			end
			if (dl_start)
				bk_ena <= 1'b0;
		end
	end

	// Wishbone cycle, one outstanding
	always_ff @(posedge clk_sys) begin
		if (!RESET_N)
			cyc_q <= 1'b0;
		else if (wr_req || rd_req)
			cyc_q <= 1'b1;
		else if (wb_in.ack)
			cyc_q <= 1'b0;
	end

	// Byte pairing and word addressing
	always_ff @(posedge clk_sys) begin
		if (start_load)
			wb_ptr <= '0;
		if ((state == cart_pkg::XFER) && load && sd_buff_wr && !sd_buff_addr[0])
			lo_byte <= sd_buff_dout;
		if (wr_req) begin
			we_q   <= 1'b1;
			adr_q  <= wb_ptr;
			dat_q  <= {sd_buff_dout, lo_byte};
			wb_ptr <= wb_ptr + 1'b1;
		end else if (rd_req) begin
			we_q   <= 1'b0;
			adr_q  <= start_save ? '0 : wb_ptr;
			wb_ptr <= start_save ? cart_pkg::bk_addr_t'(1) : wb_ptr + 1'b1;
		end
		if (wb_in.ack && !we_q)
			hold <= wb_in.dat;
	end

endmodule

`default_nettype wire

// File: rtl/backup_ram.sv
`default_nettype none

module backup_ram (
	input  wire                    clk_sys,
	input  wire                    RESET_N,
	input  wire cart_pkg::wb_m2s_t wb_in,
	output cart_pkg::wb_s2m_t      wb_out
);

	cart_pkg::word_t mem [2**cart_pkg::BK_ADDR_W];
	cart_pkg::word_t rd_q;
	logic            ack_q;
	logic            req;

	// Ack stays a single cycle even while stb is still up
	assign req    = wb_in.cyc && wb_in.stb && !ack_q;
	assign wb_out = '{ack: ack_q, dat: rd_q};

	always_ff @(posedge clk_sys) begin
		if (!RESET_N)
			ack_q <= 1'b0;
		else
			ack_q <= req;
	end

	always_ff @(posedge clk_sys) begin
		if (req) begin
			if (wb_in.we && wb_in.sel[0])
				mem[wb_in.adr][7:0] <= wb_in.dat[7:0];
			if (wb_in.we && wb_in.sel[1])
				mem[wb_in.adr][15:8] <= wb_in.dat[15:8];
			rd_q <= mem[wb_in.adr];
		end
	end

endmodule

`default_nettype wire

// File: rtl/cart_loader_top.sv
`default_nettype none

module cart_loader_top (
	input  wire                        clk_sys,
	input  wire                        RESET_N,
	input  wire cart_pkg::ioctl_t      ioctl,
	input  wire cart_pkg::rom_layout_e rom_layout,
	input  wire                        img_mounted,
	input  wire [31:0]                 img_size,
	input  wire                        bk_save,
	input  wire                        sd_ack,
	input  wire [8:0]                  sd_buff_addr,
	input  wire cart_pkg::byte_t       sd_buff_dout,
	input  wire                        sd_buff_wr,
	input  wire                        sd_buff_rd,
	output wire cart_pkg::cart_info_t  info,
	output wire                        spc_mode,
	output wire                        rom_wr,
	output wire cart_pkg::rom_addr_t   rom_addr,
	output wire cart_pkg::word_t       rom_data,
	output wire                        aram_wr,
	output wire [15:0]                 aram_addr,
	output wire cart_pkg::word_t       aram_data,
	output wire cart_pkg::lba_t        sd_lba,
	output wire                        sd_rd,
	output wire                        sd_wr,
	output wire cart_pkg::byte_t       sd_buff_din,
	output wire                        bk_ena,
	output wire                        bk_busy
);

	wire                        cart_active;
	wire                        dl_start;
	wire cart_pkg::io_addr_t    io_addr_adj;
	wire [1:0]                  layout;
	wire cart_pkg::hdr_fields_t hdr;
	wire cart_pkg::wb_m2s_t     wb_m2s;
	wire cart_pkg::wb_s2m_t     wb_s2m;

	// ==================================================
	// Download path
	// ==================================================
	download_router u_router (
		.clk_sys, .RESET_N, .ioctl, .cart_active, .io_addr_adj,
		.rom_wr, .rom_addr, .rom_data, .aram_wr, .aram_addr, .aram_data,
		.spc_mode, .dl_start
	);

	header_capture u_header (
		.clk_sys, .RESET_N, .ioctl, .cart_active, .io_addr_adj, .rom_layout,
		.layout, .hdr
	);

	chip_detect u_detect (
		.clk_sys, .RESET_N, .cart_active, .layout, .hdr, .info
	);

	// ==================================================
	// Backup RAM path
	// ==================================================
	backup_engine u_engine (
		.clk_sys, .RESET_N, .img_mounted, .img_size, .bk_save, .dl_start,
		.sd_ack, .sd_buff_addr, .sd_buff_dout, .sd_buff_wr, .sd_buff_rd,
		.wb_in(wb_s2m), .sd_lba, .sd_rd, .sd_wr, .sd_buff_din,
		.bk_ena, .bk_busy, .wb_out(wb_m2s)
	);

	backup_ram u_bkram (
		.clk_sys, .RESET_N, .wb_in(wb_m2s), .wb_out(wb_s2m)
	);

endmodule

`default_nettype wire

// File: test/cart_loader_chk.sv
`default_nettype none

module cart_loader_chk (
	input wire                    clk_sys,
	input wire                    RESET_N,
	input wire cart_pkg::ioctl_t  ioctl,
	input wire cart_pkg::wb_m2s_t wb_m2s,
	input wire cart_pkg::wb_s2m_t wb_s2m,
	input wire                    sd_rd,
	input wire                    sd_wr,
	input wire                    rom_wr
);

	int unsigned fails = 0;

	// ==================================================
	// Wishbone classic
	// ==================================================
	ack_single: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		wb_s2m.ack |=> !wb_s2m.ack)
	else begin
		fails++;
		$error("Wishbone ack lasted longer than one cycle");
	end

	// Request and its fields stay put until the slave answers
	cyc_held: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		wb_m2s.cyc && !wb_s2m.ack |=>
		wb_m2s.cyc && wb_m2s.stb && $stable(wb_m2s.adr) && $stable(wb_m2s.we) &&
		$stable(wb_m2s.dat))
	else begin
		fails++;
		$error("Wishbone cycle dropped or changed before ack");
	end

	// ==================================================
	// SD and ROM ports
	// ==================================================
	sd_exclusive: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		!(sd_rd && sd_wr))
	else begin
		fails++;
		$error("SD read and write requested together");
	end

	rom_wr_in_cart: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		rom_wr |-> $past(ioctl.download && ioctl.wr && ioctl.index[5:1] == 5'd0))
	else begin
		fails++;
		$error("ROM write outside a cartridge download");
	end

endmodule

`default_nettype wire

// File: test/tb_cart_loader.sv
`default_nettype none

module tb_cart_loader;

	localparam int TIMEOUT = 200;

	logic                  clk_sys;
	logic                  RESET_N;
	cart_pkg::ioctl_t      ioctl;
	cart_pkg::rom_layout_e rom_layout;
	logic                  img_mounted;
	logic [31:0]           img_size;
	logic                  bk_save;
	logic                  sd_ack;
	logic [8:0]            sd_buff_addr;
	cart_pkg::byte_t       sd_buff_dout;
	logic                  sd_buff_wr;
	logic                  sd_buff_rd;
	cart_pkg::cart_info_t  info;
	logic                  spc_mode;
	logic                  rom_wr;
	cart_pkg::rom_addr_t   rom_addr;
	cart_pkg::word_t       rom_data;
	logic                  aram_wr;
	logic [15:0]           aram_addr;
	cart_pkg::word_t       aram_data;
	cart_pkg::lba_t        sd_lba;
	logic                  sd_rd;
	logic                  sd_wr;
	cart_pkg::byte_t       sd_buff_din;
	logic                  bk_ena;
	logic                  bk_busy;

	int unsigned     errors = 0;
	int unsigned     timeouts = 0;
	int unsigned     rd_reqs = 0;
	int unsigned     wr_reqs = 0;
	logic            rd_q = 1'b0;
	logic            wr_q = 1'b0;
	cart_pkg::byte_t image [1024];
	cart_pkg::byte_t saved [1024];

	cart_loader_top uut (.*);

	bind cart_loader_top cart_loader_chk u_chk (
		.clk_sys(clk_sys), .RESET_N(RESET_N), .ioctl(ioctl), .wb_m2s(wb_m2s),
		.wb_s2m(wb_s2m), .sd_rd(sd_rd), .sd_wr(sd_wr), .rom_wr(rom_wr)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Counts sector requests per direction
	always @(posedge clk_sys) begin
		rd_q <= sd_rd;
		wr_q <= sd_wr;
		if (sd_rd && !rd_q)
			rd_reqs <= rd_reqs + 1;
		if (sd_wr && !wr_q)
			wr_reqs <= wr_reqs + 1;
	end

	// ==================================================
	// Helpers
	// ==================================================
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic end_run();
		int unsigned proto;
		proto = uut.u_chk.fails;
		$display("Summary: %0d value errors, %0d assertion failures, %0d timeouts",
		         errors, proto, timeouts);
		if (errors == 0 && proto == 0 && timeouts == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic timed_out(input string what);
		timeouts++;
		$display("Timeout while waiting for %s at %0t", what, $time);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		assert (got === exp)
		else begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic start_download(input logic [7:0] index, input logic [23:0] filesize);
		ioctl.index    = index;
		ioctl.filesize = filesize;
		ioctl.download = 1'b1;
		tick();
	endtask

	// Chip detect settles one cycle after the download ends
	task automatic end_download();
		ioctl.download = 1'b0;
		tick();
		tick();
	endtask

	// Outputs of the router are valid on return
	task automatic upload_word(input cart_pkg::io_addr_t addr, input cart_pkg::word_t data);
		ioctl.addr = addr;
		ioctl.dout = data;
		ioctl.wr   = 1'b1;
		tick();
		ioctl.wr   = 1'b0;
	endtask

	task automatic check_rom_write(input cart_pkg::io_addr_t addr, input cart_pkg::word_t data);
		cart_pkg::io_addr_t exp_addr;
		exp_addr = addr - 25'd512;
		upload_word(addr, data);
		check_value("rom_wr", rom_wr, 1);
		check_value("rom_addr", rom_addr, exp_addr[23:0]);
		check_value("rom_data", rom_data, data);
	endtask

	task automatic check_aram_write(input cart_pkg::io_addr_t addr, input cart_pkg::word_t data);
		cart_pkg::io_addr_t exp_addr;
		exp_addr = addr - 25'd256;
		upload_word(addr, data);
		check_value("rom_wr", rom_wr, 0);
		if (addr < 25'h10100) begin
			check_value("aram_wr", aram_wr, 1);
			check_value("aram_addr", aram_addr, exp_addr[15:0]);
			check_value("aram_data", aram_data, data);
		end else
			check_value("aram_wr", aram_wr, 0);
	endtask

	task automatic mount_image(input logic [31:0] size);
		img_size    = size;
		img_mounted = 1'b1;
		tick();
		img_mounted = 1'b0;
	endtask

	task automatic pulse_save();
		bk_save = 1'b1;
		tick();
		bk_save = 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (bk_busy && n < TIMEOUT) begin
			tick();
			n++;
		end
		if (bk_busy)
			timed_out("bk_busy to fall");
	endtask

	// ==================================================
	// SD host model serving two sectors per transfer
	// ==================================================
	task automatic serve_sectors(input bit save);
		int n;
		for (int s = 0; s < 2; s++) begin
			n = 0;
			while (!(save ? sd_wr : sd_rd) && n < TIMEOUT) begin
				tick();
				n++;
			end
			if (!(save ? sd_wr : sd_rd))
				timed_out("an SD sector request");
			check_value("sd_lba", sd_lba, s);
			check_value("bk_busy", bk_busy, 1);
			sd_ack = 1'b1;
			tick();
			check_value(save ? "sd_wr" : "sd_rd", save ? sd_wr : sd_rd, 0);
			repeat (3) tick();
			for (int i = 0; i < 512; i++) begin
				sd_buff_addr = 9'(i);
				if (save)
					sd_buff_rd = 1'b1;
				else begin
					sd_buff_dout = image[s*512 + i];
					sd_buff_wr   = 1'b1;
				end
				tick();
				if (save)
					saved[s*512 + i] = sd_buff_din;
				sd_buff_rd = 1'b0;
				sd_buff_wr = 1'b0;
				repeat (4) tick();
			end
			sd_ack = 1'b0;
			tick();
		end
	endtask

	// ==================================================
	// Stimulus
	// ==================================================
	initial begin
		void'($urandom(32'h26e37f09));
		RESET_N      = 1'b0;
		ioctl        = '0;
		rom_layout   = cart_pkg::LOROM;
		img_mounted  = 1'b0;
		img_size     = '0;
		bk_save      = 1'b0;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		sd_buff_rd   = 1'b0;
		repeat (5) @(posedge clk_sys);
		#1;
		RESET_N = 1'b1;
		check_value("bk_ena", bk_ena, 0);
		check_value("rom_type", info.rom_type, 0);

		// Copier header shifts every ROM address by 512
		start_download(8'h00, 24'h008200);
		check_rom_write(25'h00200, 16'h1234);
		check_rom_write(25'h00202, 16'hBEEF);
		check_rom_write(25'h12346, 16'h0F5A);
		end_download();

		// LoROM DSP1
		rom_layout = cart_pkg::LOROM;
		start_download(8'h00, 24'h080000);
		upload_word(25'h00000, 16'h0000);
		upload_word(25'h07FD4, 16'h2000);
		upload_word(25'h07FD6, 16'h0903);
		upload_word(25'h07FD8, 16'h0003);
		end_download();
		check_value("rom_type", info.rom_type, 8'h80);
		check_value("rom_mask", info.rom_mask, 24'h3FFFFF);
		check_value("ram_mask", info.ram_mask, 24'h001FFF);

		// GSU at the HiROM offset with the layout taken from the index
		rom_layout = cart_pkg::AUTO;
		start_download(8'h40, 24'h100000);
		upload_word(25'h00000, 16'h0000);
		upload_word(25'h0FFD4, 16'h2000);
		upload_word(25'h0FFD6, 16'h0A1A);
		upload_word(25'h0FFD8, 16'h0005);
		end_download();
		check_value("rom_type", info.rom_type, 8'h71);
		check_value("rom_mask", info.rom_mask, 24'h3FFFFF);
		check_value("ram_mask", info.ram_mask, 24'h00FFFF);

		// SPC file
		start_download(8'h02, 24'h010200);
		check_aram_write(25'h00100, 16'h1111);
		check_aram_write(25'h0A5A0, 16'h2222);
		check_aram_write(25'h100FE, 16'h3333);
		check_aram_write(25'h10100, 16'h4444);
		check_aram_write(25'h1FFFE, 16'h5555);
		end_download();
		check_value("spc_mode", spc_mode, 1);

		// Backup load then save of the same image
		for (int i = 0; i < 1024; i++)
			image[i] = 8'($urandom());
		mount_image(32'h0000_0200);
		serve_sectors(1'b0);
		wait_idle();
		check_value("bk_ena", bk_ena, 1);
		pulse_save();
		serve_sectors(1'b1);
		wait_idle();
		for (int i = 0; i < 1024; i++)
			check_value($sformatf("saved byte %0d", i), saved[i], image[i]);
		check_value("sd_rd requests", rd_reqs, 2);
		check_value("sd_wr requests", wr_reqs, 2);

		// Save requests without a valid image
		start_download(8'h00, 24'h000000);
		end_download();
		check_value("bk_ena", bk_ena, 0);
		pulse_save();
		repeat (20) tick();
		check_value("sd_wr requests", wr_reqs, 2);
		mount_image(32'h0000_0000);
		tick();
		check_value("bk_ena", bk_ena, 0);
		pulse_save();
		repeat (20) tick();
		check_value("sd_wr requests", wr_reqs, 2);
		check_value("sd_rd requests", rd_reqs, 2);

		end_run();
	end

endmodule

`default_nettype wire

// File: project.f
rtl/cart_pkg.sv
rtl/download_router.sv
rtl/header_capture.sv
rtl/chip_detect.sv
rtl/backup_engine.sv
rtl/backup_ram.sv
rtl/cart_loader_top.sv
test/cart_loader_chk.sv
test/tb_cart_loader.sv

// File: Makefile
# Verilator flow for the cartridge loader

VERILATOR ?= verilator
TOP       ?= tb_cart_loader
RTL_TOP   ?= cart_loader_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert --Wno-fatal --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only -Wall

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter rtl/%,$(SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	-$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
